// File: mem_cases.txt
// Columns: ie _ iaddr _ de _ daddr _ drw _ din _ expect_hit, all hex.
// A line with ie and de both 0 pulses reset for five cycles.
// Cold instruction read, then a hit.
1_00000104_0_00000000_0_00000000_0
1_00000104_0_00000000_0_00000000_1
// Cold data read, then a hit.
0_00000000_1_00000208_0_00000000_0
0_00000000_1_00000208_0_00000000_1
// Store goes through to SRAM and is allocated, both ports then hit.
0_00000000_1_0000030c_1_cafef00d_0
0_00000000_1_0000030c_0_00000000_1
1_0000030c_0_00000000_0_00000000_1
// Same index with different tags.
0_00000000_1_00000410_0_00000000_0
0_00000000_1_00000510_0_00000000_0
0_00000000_1_00000410_0_00000000_0
1_00000510_0_00000000_0_00000000_0
1_00000510_0_00000000_0_00000000_1
// Both ports miss, then both hit.
1_00000614_1_00000718_0_00000000_0
1_00000614_1_00000718_0_00000000_1
// Instruction miss beside a store.
1_0000081c_1_00000920_1_12345678_0
1_0000081c_1_00000920_0_00000000_1
// Data miss beside an instruction hit, and the reverse.
1_00000104_1_00000a24_0_00000000_0
1_00000b28_1_00000208_0_00000000_0
// Both miss on one index, only the instruction line is kept.
1_00000c2c_1_00000d2c_0_00000000_0
1_00000c2c_0_00000000_0_00000000_1
0_00000000_1_00000d2c_0_00000000_0
// Reset empties the cache while the SRAM keeps the store.
0_00000000_0_00000000_0_00000000_0
1_00000104_0_00000000_0_00000000_0
0_00000000_1_0000030c_0_00000000_0
0_00000000_1_0000030c_0_00000000_1

// File: vlog.f
+incdir+.
cache_pkg.sv
sram_pkg.sv
cache_ram.sv
cache_ctrl.sv
sram_ctrl.sv
mem_hierarchy.sv
tb_sram_model.sv
tb_mem_hierarchy.sv

// File: run_sim.sh
#!/bin/sh
# Build the memory hierarchy testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --top-module tb_mem_hierarchy -f vlog.f \
	-o tb_mem_hierarchy > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_mem_hierarchy > sim.log 2>&1
cat sim.log
grep -q "\*\*\* FAILED \*\*\*" sim.log && exit 1
grep -q "\*\*\* PASSED \*\*\*" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0

// File: tb_mem_hierarchy.sv
// Testbench for the memory hierarchy.
// Runs access cases from a file against a shadow memory and checks hits and returned words.
`include "mem_cfg.svh"

module tb_mem_hierarchy import cache_pkg::*, sram_pkg::*; ();

	localparam int MAX_CASES = 64;

	logic        clk = 1'b0;
	logic        rst;
	logic        ie;
	logic        de;
	logic        drw;
	addr_t       iaddr;
	addr_t       daddr;
	data_t       din;
	data_t       iout;
	data_t       dout;
	logic        cpu_stall;
	logic        sram_ce;
	logic        sram_oe;
	logic        sram_we;
	sram_addr_t  sram_addr;
	half_t       sram_wdata;
	half_t       sram_rdata;
	int unsigned accesses;

	// One case per entry with ie, iaddr, de, daddr, drw, din and expect_hit as hex fields.
	logic [111:0] cases [MAX_CASES];
	int           n_cases = 0;
	// Words written by the testbench.
	// All others follow the fill rule.
	data_t        shadow [addr_t];
	int unsigned  cycles = 0;
	int unsigned  cycle_limit = 0;

	mem_hierarchy i_mem_hierarchy (
		.clk, .rst, .ie, .de, .iaddr, .daddr, .drw, .din,
		.iout, .dout, .cpu_stall,
		.sram_ce, .sram_oe, .sram_we, .sram_addr, .sram_wdata, .sram_rdata
	);

	tb_sram_model sram (
		.clk, .sram_ce, .sram_oe, .sram_we, .sram_addr, .sram_wdata, .sram_rdata,
		.accesses
	);

	always #5 clk = ~clk;

	// Ends a run that stops making progress.
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit != 0 && cycles >= cycle_limit)
			stop_run($sformatf("Timeout: the cases did not finish within %0d cycles",
				cycle_limit));
	end

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("*** FAILED ***");
		$fatal(1, "Simulation stopped");
	endtask

	function automatic data_t expected_word(input addr_t a);
		if (shadow.exists(a))
			return shadow[a];
		return ~a;
	endfunction

	task automatic check_data(input string port, input data_t got, input data_t expected);
		if (got !== expected)
			stop_run($sformatf("FAIL @%0t: %s returned %h, expected %h",
				$time, port, got, expected));
	endtask

	// A hit completes without a stall and leaves the SRAM idle.
	task automatic check_hit(input logic expect_hit, input logic stalled,
		input int unsigned traffic);
		if (expect_hit && (stalled !== 1'b0 || traffic != 0))
			stop_run($sformatf("FAIL @%0t: expected a hit, saw stall %b and %0d accesses",
				$time, stalled, traffic));
		else if (!expect_hit && (stalled !== 1'b1 || traffic == 0))
			stop_run($sformatf("FAIL @%0t: expected a miss, saw stall %b and %0d accesses",
				$time, stalled, traffic));
	endtask

	// Reset covers five rising edges.
	task automatic apply_reset();
		ie = 1'b0;
		de = 1'b0;
		drw = 1'b0;
		rst = 1'b1;
		repeat (5) @(negedge clk);
		rst = 1'b0;
	endtask

	// Runs one case from a falling edge and returns on a falling edge.
	task automatic run_case(input logic [111:0] c);
		logic        c_ie;
		logic        c_de;
		logic        c_drw;
		logic        c_hit;
		logic        stalled;
		addr_t       c_iaddr;
		addr_t       c_daddr;
		data_t       c_din;
		int unsigned start;
		c_ie = c[108];
		c_iaddr = c[107:76];
		c_de = c[72];
		c_daddr = c[71:40];
		c_drw = c[36];
		c_din = c[35:4];
		c_hit = c[0];
		if (!c_ie && !c_de) begin
			apply_reset();
		end else begin
			ie = c_ie;
			iaddr = c_iaddr;
			de = c_de;
			daddr = c_daddr;
			drw = c_drw;
			din = c_din;
			#1;
			stalled = cpu_stall;
			start = accesses;
			// Inputs stay put until the stall falls.
			while (cpu_stall) begin
				@(negedge clk);
				#1;
			end
			if (c_ie)
				check_data("iout", iout, expected_word(c_iaddr));
			if (c_de && !c_drw)
				check_data("dout", dout, expected_word(c_daddr));
			if (c_de && c_drw)
				shadow[c_daddr] = c_din;
			@(negedge clk);
			// An idle cycle lets a stray SRAM access reach the count.
			ie = 1'b0;
			de = 1'b0;
			@(negedge clk);
			check_hit(c_hit, stalled, accesses - start);
		end
	endtask

	initial begin
		rst = 1'b1;
		ie = 1'b0;
		de = 1'b0;
		drw = 1'b0;
		iaddr = '0;
		daddr = '0;
		din = '0;
		// Entries left at all ones mark the end of the list.
		foreach (cases[k])
			cases[k] = '1;
		$readmemh("mem_cases.txt", cases);
		while (n_cases < MAX_CASES && cases[n_cases][111:108] != 4'hf)
			n_cases++;
		if (n_cases == 0)
			stop_run("No access cases were read from mem_cases.txt");
		// Worst case is two ports of two halves, each with wait states and a gap.
		cycle_limit = n_cases * 4 * (`SRAM_WAIT_CYCLES + 2) + 20;
		apply_reset();
		for (int k = 0; k < n_cases; k++)
			run_case(cases[k]);
		$display("*** PASSED ***");
		$finish;
	end

endmodule

// File: tb_sram_model.sv
// Behavioral asynchronous SRAM on a 16-bit bus for the testbench.
// Unwritten words read as their byte address inverted and halfword accesses are counted.
module tb_sram_model import sram_pkg::*; (
	input  logic        clk,
	input  logic        sram_ce,
	input  logic        sram_oe,
	input  logic        sram_we,
	input  sram_addr_t  sram_addr,
	input  half_t       sram_wdata,
	output half_t       sram_rdata,
	output int unsigned accesses
);

	// Only written halfwords are stored, the rest come from the fill rule.
	half_t       mem [sram_addr_t];
	half_t       rdata_q = '0;
	logic        ce_q = 1'b1;
	int unsigned count = 0;

	// Word at byte address A holds A inverted.
	// The halfword address carries byte address bits 23 down to 1.
	function automatic half_t pattern_half(input sram_addr_t a);
		logic [31:0] word;
		word = ~{8'h00, a[22:1], 2'b00};
		return a[0] ? word[31:16] : word[15:0];
	endfunction

	// Read data settles half a cycle after ce and oe go low.
	always @(negedge clk) begin
		if (!sram_ce && !sram_oe)
			rdata_q <= mem.exists(sram_addr) ? mem[sram_addr] : pattern_half(sram_addr);
		else
			rdata_q <= '0;
	end

	assign sram_rdata = rdata_q;

	// Writes land while ce and we are low.
	// One access is counted per falling edge of ce.
	always @(posedge clk) begin
		if (!sram_ce && !sram_we)
			mem[sram_addr] = sram_wdata;
		if (!sram_ce && ce_q)
			count <= count + 1;
		ce_q <= sram_ce;
	end

	assign accesses = count;

endmodule

// File: mem_hierarchy.sv
// Memory hierarchy top level.
// Unified direct-mapped cache in front of a halfword SRAM controller.
module mem_hierarchy import cache_pkg::*, sram_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       ie,
	input  logic       de,
	input  addr_t      iaddr,
	input  addr_t      daddr,
	input  logic       drw,
	input  data_t      din,
	output data_t      iout,
	output data_t      dout,
	output logic       cpu_stall,
	output logic       sram_ce,
	output logic       sram_oe,
	output logic       sram_we,
	output sram_addr_t sram_addr,
	output half_t      sram_wdata,
	input  half_t      sram_rdata
);

	logic   i_we;
	logic   d_we;
	index_t i_index;
	index_t d_index;
	data_t  i_wdata;
	data_t  d_wdata;
	data_t  i_rdata;
	data_t  d_rdata;
	tag_t   i_wtag;
	tag_t   d_wtag;
	tag_t   i_rtag;
	tag_t   d_rtag;
	logic   sram_ie;
	logic   sram_de;
	logic   sram_drw;
	logic   sram_nrdy;
	addr_t  sram_iaddr;
	addr_t  sram_daddr;
	data_t  sram_din;
	data_t  sram_iout;
	data_t  sram_dout;

	cache_ctrl i_cache_ctrl (
		.clk, .rst, .ie, .de, .drw, .iaddr, .daddr, .din,
		.iout, .dout, .cpu_stall,
		.i_we, .d_we, .i_index, .d_index, .i_wdata, .d_wdata,
		.i_wtag, .d_wtag, .i_rdata, .d_rdata, .i_rtag, .d_rtag,
		.sram_ie, .sram_de, .sram_drw, .sram_iaddr, .sram_daddr, .sram_din,
		.sram_iout, .sram_dout, .sram_nrdy
	);

	// Unified storage, port a serves instructions and port b data.
	cache_ram #(.WIDTH($bits(data_t))) data_array (
		.clk, .wea(i_we), .web(d_we), .addra(i_index), .addrb(d_index),
		.dia(i_wdata), .dib(d_wdata), .doa(i_rdata), .dob(d_rdata)
	);

	cache_ram #(.WIDTH($bits(tag_t))) tag_array (
		.clk, .wea(i_we), .web(d_we), .addra(i_index), .addrb(d_index),
		.dia(i_wtag), .dib(d_wtag), .doa(i_rtag), .dob(d_rtag)
	);

	sram_ctrl i_sram_ctrl (
		.clk, .rst,
		.sram_ie, .sram_de, .sram_drw, .sram_iaddr, .sram_daddr, .sram_din,
		.sram_iout, .sram_dout, .sram_nrdy,
		.sram_ce, .sram_oe, .sram_we, .sram_addr, .sram_wdata, .sram_rdata
	);

endmodule

// File: sram_ctrl.sv
// SRAM controller.
// Serves data then instruction words as two halfword cycles with wait states.
`include "mem_cfg.svh"

module sram_ctrl import cache_pkg::*, sram_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	// Requests from the cache controller.
	input  logic       sram_ie,
	input  logic       sram_de,
	input  logic       sram_drw,
	input  addr_t      sram_iaddr,
	input  addr_t      sram_daddr,
	input  data_t      sram_din,
	output data_t      sram_iout,
	output data_t      sram_dout,
	output logic       sram_nrdy,
	// Asynchronous SRAM bus, strobes active low.
	output logic       sram_ce,
	output logic       sram_oe,
	output logic       sram_we,
	output sram_addr_t sram_addr,
	output half_t      sram_wdata,
	input  half_t      sram_rdata
);

	localparam int WAIT_CYC = `SRAM_WAIT_CYCLES;
	localparam int CNT_W = $clog2(WAIT_CYC + 1);
	// Last cycle with the strobes asserted.
	localparam logic [CNT_W-1:0] LAST = CNT_W'(WAIT_CYC - 1);
	// Idle cycle with ce high between the two halves.
	localparam logic [CNT_W-1:0] GAP = CNT_W'(WAIT_CYC);

	sram_state_t      state;
	logic [CNT_W-1:0] cnt;
	logic             cur_d;
	logic             hi;
	logic             active;
	logic             wr;
	logic             sample;
	addr_t            word_addr;

	// Current port and half.
	assign hi        = (state == s_hi_half);
	assign word_addr = cur_d ? sram_daddr : sram_iaddr;
	assign wr        = cur_d && sram_drw;

	// Strobes are held for the wait cycles of each half.
	assign active = ((state == s_lo_half) || hi) && (cnt != GAP);
	assign sample = active && !wr && (cnt == LAST);

	assign sram_ce = !active;
	assign sram_oe = !(active && !wr);
	assign sram_we = !(active && wr);

	// Halfword address is the word address times 2, plus 1 for the high half.
	assign sram_addr  = {word_addr[23:2], hi};
	assign sram_wdata = hi ? sram_din[31:16] : sram_din[15:0];

	// Ready for exactly one cycle once all ports are served.
	assign sram_nrdy = (state != s_done);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= s_idle;
			cnt <= '0;
			cur_d <= 1'b0;
		end else begin
			case (state)
			s_idle: begin
				cnt <= '0;
				// Data port goes first.
				if (sram_de || sram_ie) begin
					cur_d <= sram_de;
					state <= s_lo_half;
				end
			end
			s_lo_half: begin
				if (cnt == GAP) begin
					cnt <= '0;
					state <= s_hi_half;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
			s_hi_half: begin
				if (cnt == LAST) begin
					cnt <= '0;
					state <= (cur_d && sram_ie) ? s_next_port : s_done;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
			s_next_port: begin
				// Gap cycle, then the instruction word.
				cur_d <= 1'b0;
				state <= s_lo_half;
			end
			s_done: state <= s_idle;
			default: state <= s_idle;
			endcase
		end
	end

	// Read words are assembled half by half.
	always_ff @(posedge clk) begin
		if (sample) begin
			if (cur_d) begin
				if (hi)
					sram_dout[31:16] <= sram_rdata;
				else
					sram_dout[15:0] <= sram_rdata;
			end else begin
				if (hi)
					sram_iout[31:16] <= sram_rdata;
				else
					sram_iout[15:0] <= sram_rdata;
			end
		end
	end

endmodule

// File: cache_ctrl.sv
// Cache controller for the unified direct-mapped, write-through cache.
// Detects hits on both ports, runs miss and write service and stalls the CPU.
module cache_ctrl import cache_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	// Processor side.
	input  logic   ie,
	input  logic   de,
	input  logic   drw,
	input  addr_t  iaddr,
	input  addr_t  daddr,
	input  data_t  din,
	output data_t  iout,
	output data_t  dout,
	output logic   cpu_stall,
	// Array side, port a is instruction and port b is data.
	output logic   i_we,
	output logic   d_we,
	output index_t i_index,
	output index_t d_index,
	output data_t  i_wdata,
	output data_t  d_wdata,
	output tag_t   i_wtag,
	output tag_t   d_wtag,
	input  data_t  i_rdata,
	input  data_t  d_rdata,
	input  tag_t   i_rtag,
	input  tag_t   d_rtag,
	// SRAM controller side.
	output logic   sram_ie,
	output logic   sram_de,
	output logic   sram_drw,
	output addr_t  sram_iaddr,
	output addr_t  sram_daddr,
	output data_t  sram_din,
	input  data_t  sram_iout,
	input  data_t  sram_dout,
	input  logic   sram_nrdy
);

	localparam int IDX_W = $bits(index_t);
	localparam int DEPTH = 2 ** IDX_W;

	cache_state_t     state;
	cache_state_t     next_state;
	logic [DEPTH-1:0] valid;
	logic             ihit;
	logic             dhit;
	logic             i_fill;
	logic             d_fill;
	logic             d_wr;

	// Address split into index and tag.
	assign i_index = iaddr[IDX_W+1:2];
	assign d_index = daddr[IDX_W+1:2];
	assign i_wtag  = iaddr[31:IDX_W+2];
	assign d_wtag  = daddr[31:IDX_W+2];

	// A line hits only when valid and its stored tag matches.
	assign ihit = valid[i_index] && (i_rtag == i_wtag);
	assign dhit = valid[d_index] && (d_rtag == d_wtag);

	// Decoded service in progress.
	assign i_fill = (state == c_i_miss) || (state == c_both_miss) ||
		(state == c_write_i_miss);
	assign d_fill = (state == c_d_miss) || (state == c_both_miss);
	assign d_wr   = (state == c_d_write) || (state == c_write_i_miss);

	// Pick the service from hit, enable and write conditions.
	// The cases are disjoint.
	always_comb begin
		next_state = state;
		if (state == c_idle) begin
			if (de && !drw && !dhit && (!ie || ihit))
				next_state = c_d_miss;
			else if (ie && !ihit && (!de || (dhit && !drw)))
				next_state = c_i_miss;
			else if (ie && de && !ihit && !dhit && !drw)
				next_state = c_both_miss;
			else if (de && drw && (!ie || ihit))
				next_state = c_d_write;
			else if (ie && de && drw && !ihit)
				next_state = c_write_i_miss;
		end else if (!sram_nrdy) begin
			// SRAM finished, this is the completing cycle.
			next_state = c_idle;
		end
	end

	// Stall rises in the request cycle and falls in the completing cycle.
	assign cpu_stall = (next_state != c_idle);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= c_idle;
			valid <= '0;
		end else begin
			state <= next_state;
			if (i_we)
				valid[i_index] <= 1'b1;
			if (d_we)
				valid[d_index] <= 1'b1;
		end
	end

	// Arrays are written once, when the SRAM reports completion.
	assign i_we = i_fill && !sram_nrdy;
	// On an index collision only the instruction line is kept.
	assign d_we = (d_fill || d_wr) && !sram_nrdy && !(i_we && (i_index == d_index));

	// Write allocate takes the store data, a fill takes the SRAM word.
	assign i_wdata = sram_iout;
	assign d_wdata = d_wr ? din : sram_dout;

	// Results come from the SRAM words during a fill, else from the arrays.
	assign iout = i_fill ? sram_iout : i_rdata;
	assign dout = d_fill ? sram_dout : d_rdata;

	// Requests toward the SRAM controller.
	assign sram_ie    = i_fill;
	assign sram_de    = d_fill || d_wr;
	assign sram_drw   = drw;
	assign sram_iaddr = iaddr;
	assign sram_daddr = daddr;
	assign sram_din   = din;

endmodule

// File: cache_ram.sv
// Two-port cache array.
// Rising-edge writes and combinational reads on both ports.
module cache_ram import cache_pkg::*; #(
	parameter int WIDTH = 32
) (
	input  logic             clk,
	input  logic             wea,
	input  logic             web,
	input  index_t           addra,
	input  index_t           addrb,
	input  logic [WIDTH-1:0] dia,
	input  logic [WIDTH-1:0] dib,
	output logic [WIDTH-1:0] doa,
	output logic [WIDTH-1:0] dob
);

	localparam int DEPTH = 2 ** $bits(index_t);

	logic [WIDTH-1:0] mem [DEPTH];

	// Port a is written last, so it wins a same-index collision.
	always_ff @(posedge clk) begin
		if (web)
			mem[addrb] <= dib;
		if (wea)
			mem[addra] <= dia;
	end

	// Reads see the contents before this cycle's write.
	assign doa = mem[addra];
	assign dob = mem[addrb];

endmodule

// File: sram_pkg.sv
// SRAM bus types.
// Halfword address and data plus the access sequencer states.
package sram_pkg;

	// Halfword address, byte address bits 23 down to 1.
	typedef logic [22:0] sram_addr_t;

	// One halfword on the SRAM data bus.
	typedef logic [15:0] half_t;

	// Sequencer states.
	// The gap between halves sits in the tail of lo_half.
	typedef enum logic [2:0] {
		s_idle,
		s_lo_half,
		s_hi_half,
		s_next_port,
		s_done
	} sram_state_t;

endpackage

// File: cache_pkg.sv
// Cache types.
// Address, data, index and tag widths and the cache controller states.
`include "mem_cfg.svh"

package cache_pkg;

	// Processor byte address.
	typedef logic [31:0] addr_t;

	// Data word, also one cache line.
	typedef logic [31:0] data_t;

	// Word index into the cache arrays.
	typedef logic [`CACHE_INDEX_BITS-1:0] index_t;

	// Address bits above the index and the byte offset.
	typedef logic [29-`CACHE_INDEX_BITS:0] tag_t;

	// Controller states, one per combination of outstanding service.
	typedef enum logic [2:0] {
		c_idle,
		c_d_miss,
		c_i_miss,
		c_both_miss,
		c_d_write,
		c_write_i_miss
	} cache_state_t;

endpackage

// File: mem_cfg.svh
// Memory hierarchy configuration.
// Cache geometry and SRAM bus timing shared by the packages and the RTL.
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// Number of cache index bits.
// The cache holds 2 to this power one-word lines.
`define CACHE_INDEX_BITS 6

// Cycles each halfword access is held on the SRAM bus.
// Read data is sampled in the last of these cycles.
`define SRAM_WAIT_CYCLES 3

`endif
